// File: bench/core_tb.sv
`default_nettype none

module core_tb import uop_pkg::*; ();

    logic clk, rstn, instr_valid_0, instr_valid_1;
    logic [31:0] instr_0, instr_1, pc_0, pc_1;
    logic commit_valid_0, commit_valid_1, commit_ine_0, commit_ine_1;
    logic [4:0] commit_rd_0, commit_rd_1;
    logic [31:0] commit_data_0, commit_data_1, commit_pc_0, commit_pc_1;

    logic [31:0] mregs [32];
    logic [31:0] last_commit [32];
    int          ready_at [32];
    logic [63:0] cnt_model;
    logic [31:0] lfsr_state, pc_next;
    int          cyc, err_cnt, chk_cnt;
    // expected commit pipeline, stage 0 is the issue slot.
    logic        ev [2][5], eine [2][5], ewen [2][5], eknown [2][5];
    logic [4:0]  erd [2][5];
    logic [31:0] edata [2][5], epc [2][5];

    dual_issue_core dut0 (.*);

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cnt_model <= rstn ? cnt_model + 64'd1 : 64'd0;
        for (int l = 0; l < 2; l++) begin
            for (int s = 4; s >= 1; s--) begin
                ev[l][s]     = rstn & ev[l][s-1];
                eine[l][s]   = eine[l][s-1];
                ewen[l][s]   = ewen[l][s-1];
                eknown[l][s] = eknown[l][s-1];
                erd[l][s]    = erd[l][s-1];
                edata[l][s]  = edata[l][s-1];
                epc[l][s]    = epc[l][s-1];
            end
        end
    end

    always @(negedge clk) begin
        if (rstn) chk_cnt += int'(ev[0][4]) + int'(ev[1][4]);
        if (commit_valid_0 && !commit_ine_0) last_commit[commit_rd_0] = commit_data_0;
        if (commit_valid_1 && !commit_ine_1) last_commit[commit_rd_1] = commit_data_1;
    end

    task automatic mismatch(input string name, input logic [31:0] got, input logic [31:0] exp);
        $display("Mismatch %s: got %h expected %h", name, got, exp);
        err_cnt++;
    endtask

    v0: assert property (@(negedge clk) disable iff (!rstn) commit_valid_0 == ev[0][4])
        else mismatch("commit_valid_0", 32'(commit_valid_0), 32'(ev[0][4]));
    v1: assert property (@(negedge clk) disable iff (!rstn) commit_valid_1 == ev[1][4])
        else mismatch("commit_valid_1", 32'(commit_valid_1), 32'(ev[1][4]));
    r0: assert property (@(negedge clk) disable iff (!rstn) !ev[0][4] || commit_rd_0 == erd[0][4])
        else mismatch("commit_rd_0", 32'(commit_rd_0), 32'(erd[0][4]));
    r1: assert property (@(negedge clk) disable iff (!rstn) !ev[1][4] || commit_rd_1 == erd[1][4])
        else mismatch("commit_rd_1", 32'(commit_rd_1), 32'(erd[1][4]));
    p0: assert property (@(negedge clk) disable iff (!rstn) !ev[0][4] || commit_pc_0 == epc[0][4])
        else mismatch("commit_pc_0", commit_pc_0, epc[0][4]);
    p1: assert property (@(negedge clk) disable iff (!rstn) !ev[1][4] || commit_pc_1 == epc[1][4])
        else mismatch("commit_pc_1", commit_pc_1, epc[1][4]);
    i0: assert property (@(negedge clk) disable iff (!rstn)
            commit_ine_0 == (ev[0][4] && eine[0][4]))
        else mismatch("commit_ine_0", 32'(commit_ine_0), 32'(ev[0][4] && eine[0][4]));
    i1: assert property (@(negedge clk) disable iff (!rstn)
            commit_ine_1 == (ev[1][4] && eine[1][4]))
        else mismatch("commit_ine_1", 32'(commit_ine_1), 32'(ev[1][4] && eine[1][4]));
    d0: assert property (@(negedge clk) disable iff (!rstn)
            !(ev[0][4] && eknown[0][4]) || commit_data_0 == edata[0][4])
        else mismatch("commit_data_0", commit_data_0, edata[0][4]);
    d1: assert property (@(negedge clk) disable iff (!rstn)
            !(ev[1][4] && eknown[1][4]) || commit_data_1 == edata[1][4])
        else mismatch("commit_data_1", commit_data_1, edata[1][4]);
    w0: assert property (@(negedge clk) disable iff (!rstn)
            dut0.write_en_0 == (ev[0][4] && ewen[0][4]))
        else mismatch("write_en_0", 32'(dut0.write_en_0), 32'(ev[0][4] && ewen[0][4]));
    w1: assert property (@(negedge clk) disable iff (!rstn)
            dut0.write_en_1 == (ev[1][4] && ewen[1][4]))
        else mismatch("write_en_1", 32'(dut0.write_en_1), 32'(ev[1][4] && ewen[1][4]));

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'h80200003 : lfsr_state >> 1;
        end
        return v;
    endfunction

    function automatic logic [31:0] enc_r(input logic [31:0] base, input logic [4:0] rd,
                                          input logic [4:0] rj, input logic [4:0] rk);
        return base | {17'h0, rk, rj, rd};
    endfunction

    function automatic logic [31:0] enc_i(input logic [4:0] rd, input logic [4:0] rj,
                                          input logic [11:0] imm);
        return 32'h02800000 | {10'h0, imm, rj, rd};
    endfunction

    function automatic logic ready(input logic [4:0] r, input logic [4:0] busy);
        return r == 5'd0 || (cyc >= ready_at[r] && r != busy);
    endfunction

    // falls back to addi.w r0, r0, imm when a source is still in flight.
    function automatic logic [31:0] random_op(input logic [4:0] busy);
        logic [2:0]  kind;
        logic [4:0]  rd, rj, rk;
        logic [11:0] imm;
        kind = 3'(take_bits(3));
        rd   = 5'(take_bits(5));
        rj   = 5'(take_bits(5));
        rk   = 5'(take_bits(5));
        imm  = 12'(take_bits(12));
        if (kind == 3'd7) return ready(rj, busy) ? enc_i(rd, rj, imm) : enc_i(0, 0, imm);
        if (!ready(rj, busy) || !ready(rk, busy)) return enc_i(0, 0, imm);
        case (kind)
            3'd0:    return enc_r(32'h00100000, rd, rj, rk);
            3'd1:    return enc_r(32'h00110000, rd, rj, rk);
            3'd2:    return enc_r(32'h00120000, rd, rj, rk);
            3'd3:    return enc_r(32'h00128000, rd, rj, rk);
            3'd4:    return enc_r(32'h00148000, rd, rj, rk);
            3'd5:    return enc_r(32'h00150000, rd, rj, rk);
            default: return enc_r(32'h00158000, rd, rj, rk);
        endcase
    endfunction

    task automatic evaluate(input logic [31:0] w, input logic [31:0] pc, input int l,
                            input logic [63:0] cnt);
        logic [31:0] a, b, res;
        logic        known;
        a     = mregs[w[9:5]];
        b     = mregs[w[14:10]];
        known = 1'b1;
        res   = '0;
        if ((w & 32'hffff8000) == 32'h00100000) res = a + b;
        else if ((w & 32'hffff8000) == 32'h00110000) res = a - b;
        else if ((w & 32'hffff8000) == 32'h00120000) res = 32'($signed(a) < $signed(b));
        else if ((w & 32'hffff8000) == 32'h00128000) res = 32'(a < b);
        else if ((w & 32'hffff8000) == 32'h00148000) res = a & b;
        else if ((w & 32'hffff8000) == 32'h00150000) res = a | b;
        else if ((w & 32'hffff8000) == 32'h00158000) res = a ^ b;
        else if ((w & 32'hffc00000) == 32'h02800000) res = a + {{20{w[21]}}, w[21:10]};
        else if ((w & 32'hfe000000) == 32'h14000000) res = {w[24:5], 12'h0};
        else if ((w & 32'hfe000000) == 32'h1c000000) res = pc + {w[24:5], 12'h0};
        else if ((w & 32'hfffffc00) == 32'h00006000 && w[9:5] == 5'd0) res = cnt[31:0];
        else if ((w & 32'hfffffc00) == 32'h00006400 && w[9:5] == 5'd0) res = cnt[63:32];
        else known = 1'b0;
        ev[l][0]     = 1'b1;
        erd[l][0]    = w[4:0];
        edata[l][0]  = res;
        epc[l][0]    = pc;
        eine[l][0]   = !known;
        eknown[l][0] = known;
        ewen[l][0]   = known && w[4:0] != 5'd0;
    endtask

    task automatic issue(input logic v0, input logic [31:0] w0, input logic v1,
                         input logic [31:0] w1);
        @(negedge clk);
        instr_valid_0 = v0;
        instr_valid_1 = v1;
        instr_0       = w0;
        instr_1       = w1;
        pc_0          = pc_next;
        pc_1          = pc_next + 32'd4;
        ev[0][0]      = 1'b0;
        ev[1][0]      = 1'b0;
        // the counter is read one edge after issue.
        if (v0) evaluate(w0, pc_0, 0, cnt_model + 64'd1);
        if (v1) evaluate(w1, pc_1, 1, cnt_model + 64'd1);
        for (int l = 0; l < 2; l++) begin
            if (ev[l][0] && ewen[l][0]) begin
                mregs[erd[l][0]]    = edata[l][0];
                ready_at[erd[l][0]] = cyc + 3;
            end
        end
        pc_next += 32'd8;
        cyc++;
    endtask

    task automatic drain();
        int n;
        n = 0;
        issue(0, '0, 0, '0);
        while (ev[0][1] || ev[1][1] || ev[0][2] || ev[1][2] || ev[0][3] || ev[1][3]
               || ev[0][4] || ev[1][4]) begin
            if (n == 20) begin
                $display("pipeline did not drain within 20 cycles");
                err_cnt++;
                break;
            end
            issue(0, '0, 0, '0);
            n++;
        end
    endtask

    initial begin
        repeat (6000) @(posedge clk);
        $display("simulation ran past its cycle limit");
        $display("Test failed");
        $finish;
    end

    initial begin
        int          base;
        logic [31:0] w0;
        clk = 1'b0;
        rstn = 1'b0;
        instr_valid_0 = 1'b0;
        instr_valid_1 = 1'b0;
        instr_0 = '0;
        instr_1 = '0;
        pc_0 = '0;
        pc_1 = '0;
        lfsr_state = 32'hc7ef;
        pc_next = 32'h1c000000;
        cyc = 0;
        err_cnt = 0;
        chk_cnt = 0;
        for (int r = 0; r < 32; r++) begin
            mregs[r] = '0;
            last_commit[r] = '0;
            ready_at[r] = 0;
        end
        for (int s = 0; s < 5; s++) begin
            ev[0][s] = 1'b0;
            ev[1][s] = 1'b0;
        end
        repeat (8) @(negedge clk);
        rstn = 1'b1;
        $display("test reset: held for 8 cycles");

        base = err_cnt;
        for (int r = 1; r < 32; r += 2) begin
            issue(1, enc_i(5'(r), 5'd0, 12'(take_bits(12))), r < 31,
                  enc_i(5'(r + 1), 5'd0, 12'(take_bits(12))));
        end
        for (int i = 0; i < 300; i++) begin
            w0 = random_op(0);
            issue(1, w0, take_bits(2) != 0, random_op(w0[4:0]));
        end
        drain();
        $display("test register arithmetic: %0d errors", err_cnt - base);

        base = err_cnt;
        issue(1, enc_i(5, 0, 12'h123), 1, enc_i(5, 0, 12'h9ab));
        issue(1, enc_i(7, 0, 12'h7ff), 0, '0);
        issue(0, '0, 0, '0);
        issue(1, enc_r(32'h00100000, 6, 5, 0), 0, '0);
        issue(1, enc_r(32'h00100000, 8, 7, 7), 1, enc_r(32'h00110000, 9, 0, 5));
        drain();
        $display("test bypass and lane order: %0d errors", err_cnt - base);

        base = err_cnt;
        issue(1, 32'h14000000 | {7'h0, 20'(take_bits(20)), 5'd10}, 1,
              32'h1c000000 | {7'h0, 20'(take_bits(20)), 5'd11});
        drain();
        $display("test upper immediates: %0d errors", err_cnt - base);

        base = err_cnt;
        issue(1, enc_r(32'h00006000, 20, 0, 0), 1, enc_r(32'h00006400, 22, 0, 0));
        repeat (4) issue(0, '0, 0, '0);
        issue(1, enc_r(32'h00006000, 21, 0, 0), 0, '0);
        drain();
        cnt_delta: assert (last_commit[21] - last_commit[20] == 32'd5)
            else mismatch("counter delta", last_commit[21] - last_commit[20], 32'd5);
        cnt_high: assert (last_commit[22] == 32'd0)
            else mismatch("rdcntvh.w data", last_commit[22], 32'd0);
        $display("test counter reads: %0d errors", err_cnt - base);

        base = err_cnt;
        issue(1, 32'hffffffff, 1, 32'hfffffff3);
        repeat (2) issue(0, '0, 0, '0);
        issue(1, enc_r(32'h00100000, 12, 31, 0), 1, enc_r(32'h00150000, 13, 19, 0));
        drain();
        $display("test invalid words: %0d errors", err_cnt - base);

        $display("commits checked %0d, errors %0d", chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: bench/core_tb_sva.sv
`default_nettype none

module core_sva import uop_pkg::*; (
    input wire logic                  clk,
    input wire logic                  rstn,
    input wire logic                  instr_valid_0,
    input wire logic                  instr_valid_1,
    input wire logic                  commit_valid_0,
    input wire logic                  commit_valid_1,
    input wire logic                  commit_ine_0,
    input wire logic                  commit_ine_1,
    input wire logic [reg_addr_w-1:0] commit_rd_0,
    input wire logic [reg_addr_w-1:0] commit_rd_1,
    input wire logic                  write_en_0,
    input wire logic                  write_en_1
);

    // a reset edge leaves every valid, ine and write enable low for the next cycle.
    reset_idle: assert property (@(posedge clk) !rstn |=> !commit_valid_0 && !commit_valid_1
            && !commit_ine_0 && !commit_ine_1 && !write_en_0 && !write_en_1)
        else $error("outputs not idle after a reset edge");

    // a write needs a valid, known instruction with a nonzero rd.
    write_rule_0: assert property (@(posedge clk) disable iff (!rstn)
            write_en_0 |-> commit_valid_0 && !commit_ine_0 && commit_rd_0 != '0)
        else $error("lane 0 write enable without a valid writing commit");

    write_rule_1: assert property (@(posedge clk) disable iff (!rstn)
            write_en_1 |-> commit_valid_1 && !commit_ine_1 && commit_rd_1 != '0)
        else $error("lane 1 write enable without a valid writing commit");

    // an issued slot reaches commit exactly four edges later.
    commit_latency: assert property (@(posedge clk) disable iff (!rstn)
            commit_valid_0 == $past(instr_valid_0, 4)
            && commit_valid_1 == $past(instr_valid_1, 4))
        else $error("commit valid does not follow issue by four cycles");

endmodule

bind dual_issue_core core_sva sva0 (
    .clk(clk), .rstn(rstn),
    .instr_valid_0(instr_valid_0), .instr_valid_1(instr_valid_1),
    .commit_valid_0(commit_valid_0), .commit_valid_1(commit_valid_1),
    .commit_ine_0(commit_ine_0), .commit_ine_1(commit_ine_1),
    .commit_rd_0(commit_rd_0), .commit_rd_1(commit_rd_1),
    .write_en_0(write_en_0), .write_en_1(write_en_1)
);

`default_nettype wire

// File: dual_issue_core.f
verilog/uop_pkg.sv
verilog/uop_decode.sv
verilog/operand_read.sv
verilog/alu_execute.sv
verilog/result_writeback.sv
verilog/dual_issue_core.sv
bench/core_tb_sva.sv
bench/core_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module core_tb -f dual_issue_core.f
out=$(./obj_dir/Vcore_tb || true)
echo "$out"

if echo "$out" | grep -qx "Test passed"; then
    exit 0
fi
exit 1

// File: verilog/alu_execute.sv
`default_nettype none

module alu_execute import uop_pkg::*; (
    input  wire logic                  clk,
    input  wire logic                  rstn,
    input  wire logic                  rd_valid,
    input  wire alu_op_t               rd_op,
    input  wire logic                  rd_wen,
    input  wire logic [reg_addr_w-1:0] rd_rd,
    input  wire logic [xlen-1:0]       rd_pc,
    input  wire logic                  rd_ine,
    input  wire logic [xlen-1:0]       opnd_a,
    input  wire logic [xlen-1:0]       opnd_b,
    output logic                       ex_valid,
    output logic                       ex_wen,
    output logic [reg_addr_w-1:0]      ex_rd,
    output logic [xlen-1:0]            ex_pc,
    output logic                       ex_ine,
    output logic [xlen-1:0]            ex_result
);

    logic [xlen-1:0] result;

    always_comb begin
        case (rd_op)
            alu_add:  result = opnd_a + opnd_b; // wraps at 32 bits.
            alu_sub:  result = opnd_a - opnd_b;
            alu_and:  result = opnd_a & opnd_b;
            alu_or:   result = opnd_a | opnd_b;
            alu_xor:  result = opnd_a ^ opnd_b;
            alu_slt:  result = {{(xlen-1){1'b0}}, $signed(opnd_a) < $signed(opnd_b)};
            alu_sltu: result = {{(xlen-1){1'b0}}, opnd_a < opnd_b};
            default:  result = opnd_b; // pass_b carries the counter value through.
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            ex_valid <= 1'b0;
            ex_ine   <= 1'b0;
        end else begin
            ex_valid <= rd_valid;
            ex_ine   <= rd_valid & rd_ine;
        end
    end

    always_ff @(posedge clk) begin
        ex_wen    <= rd_wen;
        ex_rd     <= rd_rd;
        ex_pc     <= rd_pc;
        ex_result <= result;
    end

endmodule

`default_nettype wire

// File: verilog/dual_issue_core.sv
`default_nettype none

module dual_issue_core import uop_pkg::*; (
    input  wire logic                  clk,
    input  wire logic                  rstn,
    input  wire logic                  instr_valid_0,
    input  wire logic                  instr_valid_1,
    input  wire logic [31:0]           instr_0,
    input  wire logic [31:0]           instr_1,
    input  wire logic [xlen-1:0]       pc_0,
    input  wire logic [xlen-1:0]       pc_1,
    output logic                       commit_valid_0,
    output logic                       commit_valid_1,
    output logic [reg_addr_w-1:0]      commit_rd_0,
    output logic [reg_addr_w-1:0]      commit_rd_1,
    output logic [xlen-1:0]            commit_data_0,
    output logic [xlen-1:0]            commit_data_1,
    output logic [xlen-1:0]            commit_pc_0,
    output logic [xlen-1:0]            commit_pc_1,
    output logic                       commit_ine_0,
    output logic                       commit_ine_1
);

    logic                  dec_valid_0, dec_valid_1, dec_wen_0, dec_wen_1, dec_ine_0, dec_ine_1;
    alu_op_t               dec_op_0, dec_op_1;
    src1_sel_t             dec_src1_0, dec_src1_1;
    src2_sel_t             dec_src2_0, dec_src2_1;
    logic [reg_addr_w-1:0] dec_rd_0, dec_rd_1, dec_rj_0, dec_rj_1, dec_rk_0, dec_rk_1;
    logic [xlen-1:0]       dec_imm_0, dec_imm_1, dec_pc_0, dec_pc_1;
    logic                  rd_valid_0, rd_valid_1, rd_wen_0, rd_wen_1, rd_ine_0, rd_ine_1;
    alu_op_t               rd_op_0, rd_op_1;
    logic [reg_addr_w-1:0] rd_rd_0, rd_rd_1;
    logic [xlen-1:0]       rd_pc_0, rd_pc_1, opnd_a_0, opnd_a_1, opnd_b_0, opnd_b_1;
    logic                  ex_valid_0, ex_valid_1, ex_wen_0, ex_wen_1, ex_ine_0, ex_ine_1;
    logic [reg_addr_w-1:0] ex_rd_0, ex_rd_1;
    logic [xlen-1:0]       ex_pc_0, ex_pc_1, ex_result_0, ex_result_1;
    logic                  write_en_0, write_en_1;
    logic [reg_addr_w-1:0] write_addr_0, write_addr_1;
    logic [xlen-1:0]       write_data_0, write_data_1;

    uop_decode decode0 (.*);

    operand_read read0 (.*);

    alu_execute exec0 (
        .clk, .rstn, .rd_valid(rd_valid_0), .rd_op(rd_op_0), .rd_wen(rd_wen_0),
        .rd_rd(rd_rd_0), .rd_pc(rd_pc_0), .rd_ine(rd_ine_0), .opnd_a(opnd_a_0),
        .opnd_b(opnd_b_0), .ex_valid(ex_valid_0), .ex_wen(ex_wen_0), .ex_rd(ex_rd_0),
        .ex_pc(ex_pc_0), .ex_ine(ex_ine_0), .ex_result(ex_result_0)
    );

    alu_execute exec1 (
        .clk, .rstn, .rd_valid(rd_valid_1), .rd_op(rd_op_1), .rd_wen(rd_wen_1),
        .rd_rd(rd_rd_1), .rd_pc(rd_pc_1), .rd_ine(rd_ine_1), .opnd_a(opnd_a_1),
        .opnd_b(opnd_b_1), .ex_valid(ex_valid_1), .ex_wen(ex_wen_1), .ex_rd(ex_rd_1),
        .ex_pc(ex_pc_1), .ex_ine(ex_ine_1), .ex_result(ex_result_1)
    );

    result_writeback wb0 (.*);

endmodule

`default_nettype wire

// File: verilog/operand_read.sv
`default_nettype none

module operand_read import uop_pkg::*; (
    input  wire logic                  clk,
    input  wire logic                  rstn,
    input  wire logic                  dec_valid_0,
    input  wire logic                  dec_valid_1,
    input  wire alu_op_t               dec_op_0,
    input  wire alu_op_t               dec_op_1,
    input  wire src1_sel_t             dec_src1_0,
    input  wire src1_sel_t             dec_src1_1,
    input  wire src2_sel_t             dec_src2_0,
    input  wire src2_sel_t             dec_src2_1,
    input  wire logic                  dec_wen_0,
    input  wire logic                  dec_wen_1,
    input  wire logic [reg_addr_w-1:0] dec_rd_0,
    input  wire logic [reg_addr_w-1:0] dec_rd_1,
    input  wire logic [reg_addr_w-1:0] dec_rj_0,
    input  wire logic [reg_addr_w-1:0] dec_rj_1,
    input  wire logic [reg_addr_w-1:0] dec_rk_0,
    input  wire logic [reg_addr_w-1:0] dec_rk_1,
    input  wire logic [xlen-1:0]       dec_imm_0,
    input  wire logic [xlen-1:0]       dec_imm_1,
    input  wire logic [xlen-1:0]       dec_pc_0,
    input  wire logic [xlen-1:0]       dec_pc_1,
    input  wire logic                  dec_ine_0,
    input  wire logic                  dec_ine_1,
    input  wire logic                  write_en_0,
    input  wire logic                  write_en_1,
    input  wire logic [reg_addr_w-1:0] write_addr_0,
    input  wire logic [reg_addr_w-1:0] write_addr_1,
    input  wire logic [xlen-1:0]       write_data_0,
    input  wire logic [xlen-1:0]       write_data_1,
    output logic                       rd_valid_0,
    output logic                       rd_valid_1,
    output alu_op_t                    rd_op_0,
    output alu_op_t                    rd_op_1,
    output logic                       rd_wen_0,
    output logic                       rd_wen_1,
    output logic [reg_addr_w-1:0]      rd_rd_0,
    output logic [reg_addr_w-1:0]      rd_rd_1,
    output logic [xlen-1:0]            rd_pc_0,
    output logic [xlen-1:0]            rd_pc_1,
    output logic                       rd_ine_0,
    output logic                       rd_ine_1,
    output logic [xlen-1:0]            opnd_a_0,
    output logic [xlen-1:0]            opnd_a_1,
    output logic [xlen-1:0]            opnd_b_0,
    output logic [xlen-1:0]            opnd_b_1
);

    logic [xlen-1:0]  regs [2**reg_addr_w];
    logic [cnt_w-1:0] stable_cnt;

    // lane 1 is younger, so its write is checked first and lands last in the array.
    function automatic logic [xlen-1:0] read_reg(input logic [reg_addr_w-1:0] idx);
        if (idx == '0) begin
            return '0;
        end else if (write_en_1 && write_addr_1 == idx) begin
            return write_data_1;
        end else if (write_en_0 && write_addr_0 == idx) begin
            return write_data_0;
        end
        return regs[idx];
    endfunction

    function automatic logic [xlen-1:0] sel_a(input src1_sel_t sel,
                                              input logic [reg_addr_w-1:0] rj,
                                              input logic [xlen-1:0] pc);
        case (sel)
            src1_rf: return read_reg(rj);
            src1_pc: return pc;
            default: return '0;
        endcase
    endfunction

    function automatic logic [xlen-1:0] sel_b(input src2_sel_t sel,
                                              input logic [reg_addr_w-1:0] rk,
                                              input logic [xlen-1:0] imm);
        case (sel)
            src2_rf:      return read_reg(rk);
            src2_imm:     return imm;
            src2_cnt_low: return stable_cnt[xlen-1:0];
            default:      return stable_cnt[cnt_w-1:xlen];
        endcase
    endfunction

    always_ff @(posedge clk) begin
        if (write_en_0) regs[write_addr_0] <= write_data_0;
        if (write_en_1) regs[write_addr_1] <= write_data_1;
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            stable_cnt <= '0;
            rd_valid_0 <= 1'b0;
            rd_valid_1 <= 1'b0;
            rd_ine_0   <= 1'b0;
            rd_ine_1   <= 1'b0;
        end else begin
            stable_cnt <= stable_cnt + 1'b1;
            rd_valid_0 <= dec_valid_0;
            rd_valid_1 <= dec_valid_1;
            rd_ine_0   <= dec_valid_0 & dec_ine_0;
            rd_ine_1   <= dec_valid_1 & dec_ine_1;
        end
    end

    // payload only moves for a valid lane.
    always_ff @(posedge clk) begin
        if (dec_valid_0) begin
            rd_op_0  <= dec_op_0;
            rd_wen_0 <= dec_wen_0;
            rd_rd_0  <= dec_rd_0;
            rd_pc_0  <= dec_pc_0;
            opnd_a_0 <= sel_a(dec_src1_0, dec_rj_0, dec_pc_0);
            opnd_b_0 <= sel_b(dec_src2_0, dec_rk_0, dec_imm_0);
        end
        if (dec_valid_1) begin
            rd_op_1  <= dec_op_1;
            rd_wen_1 <= dec_wen_1;
            rd_rd_1  <= dec_rd_1;
            rd_pc_1  <= dec_pc_1;
            opnd_a_1 <= sel_a(dec_src1_1, dec_rj_1, dec_pc_1);
            opnd_b_1 <= sel_b(dec_src2_1, dec_rk_1, dec_imm_1);
        end
    end

endmodule

`default_nettype wire

// File: verilog/result_writeback.sv
`default_nettype none

module result_writeback import uop_pkg::*; (
    input  wire logic                  clk,
    input  wire logic                  rstn,
    input  wire logic                  ex_valid_0,
    input  wire logic                  ex_valid_1,
    input  wire logic                  ex_wen_0,
    input  wire logic                  ex_wen_1,
    input  wire logic [reg_addr_w-1:0] ex_rd_0,
    input  wire logic [reg_addr_w-1:0] ex_rd_1,
    input  wire logic [xlen-1:0]       ex_pc_0,
    input  wire logic [xlen-1:0]       ex_pc_1,
    input  wire logic                  ex_ine_0,
    input  wire logic                  ex_ine_1,
    input  wire logic [xlen-1:0]       ex_result_0,
    input  wire logic [xlen-1:0]       ex_result_1,
    output logic                       commit_valid_0,
    output logic                       commit_valid_1,
    output logic [reg_addr_w-1:0]      commit_rd_0,
    output logic [reg_addr_w-1:0]      commit_rd_1,
    output logic [xlen-1:0]            commit_data_0,
    output logic [xlen-1:0]            commit_data_1,
    output logic [xlen-1:0]            commit_pc_0,
    output logic [xlen-1:0]            commit_pc_1,
    output logic                       commit_ine_0,
    output logic                       commit_ine_1,
    output logic                       write_en_0,
    output logic                       write_en_1,
    output logic [reg_addr_w-1:0]      write_addr_0,
    output logic [reg_addr_w-1:0]      write_addr_1,
    output logic [xlen-1:0]            write_data_0,
    output logic [xlen-1:0]            write_data_1
);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            commit_valid_0 <= 1'b0;
            commit_valid_1 <= 1'b0;
            commit_ine_0   <= 1'b0;
            commit_ine_1   <= 1'b0;
            write_en_0     <= 1'b0;
            write_en_1     <= 1'b0;
        end else begin
            commit_valid_0 <= ex_valid_0;
            commit_valid_1 <= ex_valid_1;
            commit_ine_0   <= ex_valid_0 & ex_ine_0;
            commit_ine_1   <= ex_valid_1 & ex_ine_1;
            // invalid words and r0 never reach the register file.
            write_en_0     <= ex_valid_0 & ~ex_ine_0 & ex_wen_0 & (ex_rd_0 != '0);
            write_en_1     <= ex_valid_1 & ~ex_ine_1 & ex_wen_1 & (ex_rd_1 != '0);
        end
    end

    always_ff @(posedge clk) begin
        commit_rd_0   <= ex_rd_0;
        commit_rd_1   <= ex_rd_1;
        commit_data_0 <= ex_result_0;
        commit_data_1 <= ex_result_1;
        commit_pc_0   <= ex_pc_0;
        commit_pc_1   <= ex_pc_1;
    end

    assign write_addr_0 = commit_rd_0; // write port shares the commit registers.
    assign write_addr_1 = commit_rd_1;
    assign write_data_0 = commit_data_0;
    assign write_data_1 = commit_data_1;

endmodule

`default_nettype wire

// File: verilog/uop_decode.sv
`default_nettype none

module uop_decode import uop_pkg::*; (
    input  wire logic                  clk,
    input  wire logic                  rstn,
    input  wire logic                  instr_valid_0,
    input  wire logic                  instr_valid_1,
    input  wire logic [31:0]           instr_0,
    input  wire logic [31:0]           instr_1,
    input  wire logic [xlen-1:0]       pc_0,
    input  wire logic [xlen-1:0]       pc_1,
    output logic                       dec_valid_0,
    output logic                       dec_valid_1,
    output alu_op_t                    dec_op_0,
    output alu_op_t                    dec_op_1,
    output src1_sel_t                  dec_src1_0,
    output src1_sel_t                  dec_src1_1,
    output src2_sel_t                  dec_src2_0,
    output src2_sel_t                  dec_src2_1,
    output logic                       dec_wen_0,
    output logic                       dec_wen_1,
    output logic [reg_addr_w-1:0]      dec_rd_0,
    output logic [reg_addr_w-1:0]      dec_rd_1,
    output logic [reg_addr_w-1:0]      dec_rj_0,
    output logic [reg_addr_w-1:0]      dec_rj_1,
    output logic [reg_addr_w-1:0]      dec_rk_0,
    output logic [reg_addr_w-1:0]      dec_rk_1,
    output logic [xlen-1:0]            dec_imm_0,
    output logic [xlen-1:0]            dec_imm_1,
    output logic [xlen-1:0]            dec_pc_0,
    output logic [xlen-1:0]            dec_pc_1,
    output logic                       dec_ine_0,
    output logic                       dec_ine_1
);

    localparam logic [16:0] op_add_w     = 17'h00020;
    localparam logic [16:0] op_sub_w     = 17'h00022;
    localparam logic [16:0] op_slt       = 17'h00024;
    localparam logic [16:0] op_sltu      = 17'h00025;
    localparam logic [16:0] op_and       = 17'h00029;
    localparam logic [16:0] op_or        = 17'h0002a;
    localparam logic [16:0] op_xor       = 17'h0002b;
    localparam logic [9:0]  op_addi_w    = 10'h00a;
    localparam logic [6:0]  op_lu12i_w   = 7'h0a;
    localparam logic [6:0]  op_pcaddu12i = 7'h0e;
    localparam logic [21:0] op_rdcntvl_w = 22'h000018;
    localparam logic [21:0] op_rdcntvh_w = 22'h000019;

    logic [uop_w:0] dw_0;
    logic [uop_w:0] dw_1;

    // returns {known, op, src1, src2, wen}.
    function automatic logic [uop_w:0] decode_word(input logic [31:0] w);
        logic [uop_w:0] u;
        u = {1'b0, alu_add, src1_zero, src2_imm, 1'b0};
        case (w[31:15])
            op_add_w: u = {1'b1, alu_add, src1_rf, src2_rf, 1'b1};
            op_sub_w: u = {1'b1, alu_sub, src1_rf, src2_rf, 1'b1};
            op_slt:   u = {1'b1, alu_slt, src1_rf, src2_rf, 1'b1};
            op_sltu:  u = {1'b1, alu_sltu, src1_rf, src2_rf, 1'b1};
            op_and:   u = {1'b1, alu_and, src1_rf, src2_rf, 1'b1};
            op_or:    u = {1'b1, alu_or, src1_rf, src2_rf, 1'b1};
            op_xor:   u = {1'b1, alu_xor, src1_rf, src2_rf, 1'b1};
            default:  ;
        endcase
        if (w[31:22] == op_addi_w) u = {1'b1, alu_add, src1_rf, src2_imm, 1'b1};
        if (w[31:25] == op_lu12i_w) u = {1'b1, alu_add, src1_zero, src2_imm, 1'b1};
        if (w[31:25] == op_pcaddu12i) u = {1'b1, alu_add, src1_pc, src2_imm, 1'b1};
        if (w[31:10] == op_rdcntvl_w && w[9:5] == 5'd0) begin
            u = {1'b1, alu_pass_b, src1_zero, src2_cnt_low, 1'b1};
        end
        if (w[31:10] == op_rdcntvh_w && w[9:5] == 5'd0) begin
            u = {1'b1, alu_pass_b, src1_zero, src2_cnt_high, 1'b1};
        end
        return u;
    endfunction

    // upper-immediate forms carry si20, everything else si12.
    function automatic logic [xlen-1:0] decode_imm(input logic [31:0] w);
        if (w[31:28] == 4'b0001) begin
            return {w[24:5], 12'b0};
        end
        return {{20{w[21]}}, w[21:10]};
    endfunction

    assign dw_0 = decode_word(instr_0);
    assign dw_1 = decode_word(instr_1);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            dec_valid_0 <= 1'b0;
            dec_valid_1 <= 1'b0;
            dec_ine_0   <= 1'b0;
            dec_ine_1   <= 1'b0;
        end else begin
            dec_valid_0 <= instr_valid_0;
            dec_valid_1 <= instr_valid_1;
            dec_ine_0   <= instr_valid_0 & ~dw_0[uop_w];
            dec_ine_1   <= instr_valid_1 & ~dw_1[uop_w];
        end
    end

    always_ff @(posedge clk) begin
        dec_op_0   <= alu_op_t'(dw_0[uop_w-1 -: 3]);
        dec_src1_0 <= src1_sel_t'(dw_0[4:3]);
        dec_src2_0 <= src2_sel_t'(dw_0[2:1]);
        dec_wen_0  <= dw_0[0];
        dec_rd_0   <= instr_0[4:0];
        dec_rj_0   <= instr_0[9:5];
        dec_rk_0   <= instr_0[14:10];
        dec_imm_0  <= decode_imm(instr_0);
        dec_pc_0   <= pc_0;
        dec_op_1   <= alu_op_t'(dw_1[uop_w-1 -: 3]);
        dec_src1_1 <= src1_sel_t'(dw_1[4:3]);
        dec_src2_1 <= src2_sel_t'(dw_1[2:1]);
        dec_wen_1  <= dw_1[0];
        dec_rd_1   <= instr_1[4:0];
        dec_rj_1   <= instr_1[9:5];
        dec_rk_1   <= instr_1[14:10];
        dec_imm_1  <= decode_imm(instr_1);
        dec_pc_1   <= pc_1;
    end

endmodule

`default_nettype wire

// File: verilog/uop_pkg.sv
`default_nettype none

package uop_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int cnt_w      = 64; // width of the stable counter.

    typedef enum logic [2:0] {
        alu_add    = 3'd0,
        alu_sub    = 3'd1,
        alu_and    = 3'd2,
        alu_or     = 3'd3,
        alu_xor    = 3'd4,
        alu_slt    = 3'd5,
        alu_sltu   = 3'd6,
        alu_pass_b = 3'd7
    } alu_op_t;

    // first operand source.
    typedef enum logic [1:0] {
        src1_rf   = 2'd0,
        src1_pc   = 2'd1,
        src1_zero = 2'd2
    } src1_sel_t;

    // second operand source, the counter halves feed rdcntv{l,h}.w.
    typedef enum logic [1:0] {
        src2_rf       = 2'd0,
        src2_imm      = 2'd1,
        src2_cnt_low  = 2'd2,
        src2_cnt_high = 2'd3
    } src2_sel_t;

    // packed micro-op is {op, src1, src2, wen}.
    localparam int uop_w = $bits(alu_op_t) + $bits(src1_sel_t) + $bits(src2_sel_t) + 1;

endpackage

`default_nettype wire
